/* include/reverb_defs.svh */
`ifndef REVERB_DEFS_SVH
`define REVERB_DEFS_SVH

// **********************************************************************
// impulse response sizing
// **********************************************************************

// taps held in the ir memory, kept a power of two
`define IR_LEN 16
`define IR_ADDR_W 4

// **********************************************************************
// datapath widths
// **********************************************************************

`define SAMPLE_W 16   // codec sample width
`define ACC_W 40      // headroom for IR_LEN full-scale products

// probe level sent to the speaker path
`define IMPULSE_AMP 32767

`endif

/* hdl/reverb_pkg.sv */
`include "reverb_defs.svh"

package reverb_pkg;

    // signed audio word
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // one write into the ir memory
    typedef struct packed {
        logic                  en;
        logic [`IR_ADDR_W-1:0] index;  // tap number
        sample_t               data;
    } ir_write_t;

    // one convolver result
    typedef struct packed {
        logic    valid;  // single-cycle strobe
        sample_t data;
    } wet_sample_t;

endpackage

/* hdl/impulse_generator.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module impulse_generator
    import reverb_pkg::*;
(
    input  logic    audio_clk,
    input  logic    rst_in,
    input  logic    step,          // sample strobe
    input  logic    request,       // arms one probe
    output logic    impulse_done,
    output sample_t amp_out
);

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_ARMED,
        GEN_EMIT
    } gen_state_t;

    gen_state_t state;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state        <= GEN_IDLE;
            amp_out      <= '0;
            impulse_done <= 1'b0;
        end else begin
            impulse_done <= 1'b0;
            case (state)
                GEN_IDLE: begin
                    if (request) begin
                        state <= GEN_ARMED;
                    end
                end
                GEN_ARMED: begin
                    if (step) begin
                        state   <= GEN_EMIT;
                        amp_out <= sample_t'(`IMPULSE_AMP);  // full scale for one sample
                    end
                end
                GEN_EMIT: begin
                    if (step) begin
                        state        <= GEN_IDLE;
                        amp_out      <= '0;
                        impulse_done <= 1'b1;
                    end
                end
                default: begin
                    state   <= GEN_IDLE;
                    amp_out <= '0;
                end
            endcase
        end
    end

    // done closes an emitted probe sample on a strobe
    a_done_on_step: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        impulse_done |-> $past(step) && ($past(amp_out) == sample_t'(`IMPULSE_AMP))
    );

endmodule

/* hdl/impulse_recorder.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module impulse_recorder
    import reverb_pkg::*;
(
    input  logic        audio_clk,
    input  logic        rst_in,
    input  logic        audio_trigger,
    input  logic        record_trigger,
    input  logic [15:0] delay_length,    // samples of acoustic delay
    input  sample_t     mic_in,
    output logic        ir_recorded,
    output ir_write_t   ir_wr,
    output sample_t     probe_out
);

    typedef enum logic [1:0] {
        WAITING,
        DELAYING,
        RECORDING
    } rec_state_t;

    rec_state_t state;

    logic [15:0]           delay_cnt;
    logic [`IR_ADDR_W:0]   rec_cnt;       // one bit wider to reach IR_LEN
    logic                  impulse_done;
    logic                  gen_request;
    logic                  capture;

    logic                  wr_en;
    logic [`IR_ADDR_W-1:0] wr_index;
    sample_t               wr_data;

    // **********************************************************************
    // probe source
    // **********************************************************************

    assign gen_request = record_trigger && (state == WAITING);  // busy requests dropped

    impulse_generator u_impulse_gen (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .step         (audio_trigger),
        .request      (gen_request),
        .impulse_done (impulse_done),
        .amp_out      (probe_out)
    );

    // **********************************************************************
    // delay and capture sequencing
    // **********************************************************************

    assign capture = audio_trigger && (state == RECORDING) && (rec_cnt != `IR_LEN);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state       <= WAITING;
            delay_cnt   <= '0;
            rec_cnt     <= '0;
            wr_en       <= 1'b0;
            ir_recorded <= 1'b0;
        end else begin
            wr_en       <= capture;
            ir_recorded <= 1'b0;
            case (state)
                WAITING: begin
                    delay_cnt <= '0;
                    rec_cnt   <= '0;
                    if (impulse_done) begin
                        state <= DELAYING;
                    end
                end
                DELAYING: begin
                    if (audio_trigger) begin
                        if (delay_cnt == delay_length - 16'd2) begin
                            state <= RECORDING;  // next trigger is tap 0
                        end else begin
                            delay_cnt <= delay_cnt + 16'd1;
                        end
                    end
                end
                RECORDING: begin
                    if (audio_trigger) begin
                        if (rec_cnt == `IR_LEN) begin
                            ir_recorded <= 1'b1;
                            state       <= WAITING;
                        end else begin
                            rec_cnt <= rec_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= WAITING;
                end
            endcase
        end
    end

    // write payload
    always_ff @(posedge audio_clk) begin
        if (capture) begin
            wr_index <= rec_cnt[`IR_ADDR_W-1:0];
            wr_data  <= mic_in;
        end
    end

    assign ir_wr = '{en: wr_en, index: wr_index, data: wr_data};

    // tap counter stops at IR_LEN so the write index never wraps
    a_index_in_range: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        rec_cnt <= `IR_LEN
    );

endmodule

/* hdl/ir_memory.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module ir_memory
    import reverb_pkg::*;
(
    input  logic                  audio_clk,
    input  ir_write_t             wr,
    input  logic [`IR_ADDR_W-1:0] rd_addr,
    output sample_t               rd_data
);

    sample_t mem [`IR_LEN];  // one word per tap

    // write port
    always_ff @(posedge audio_clk) begin
        if (wr.en) begin
            mem[wr.index] <= wr.data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge audio_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/ir_convolver.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module ir_convolver
    import reverb_pkg::*;
(
    input  logic                  audio_clk,
    input  logic                  rst_in,
    input  logic                  audio_trigger,
    input  sample_t               dry_in,
    input  logic                  ir_loaded,      // capture finished
    input  logic                  ir_invalidate,  // new capture started
    output logic [`IR_ADDR_W-1:0] rd_addr,
    input  sample_t               rd_data,
    output logic                  ir_ready,
    output wet_sample_t           wet
);

    localparam logic [`IR_ADDR_W-1:0] LAST_TAP = `IR_ADDR_W'(`IR_LEN - 1);

    sample_t                     hist [`IR_LEN];
    logic [`IR_ADDR_W-1:0]       wr_ptr;      // next history slot
    logic [`IR_ADDR_W-1:0]       hist_idx;

    logic                        rd_busy;     // tap reads in flight
    logic                        mac_valid;   // rd_data and x_reg line up
    logic                        mac_last;
    logic                        acc_last;    // acc holds the full sum

    sample_t                     x_reg;
    logic signed [2*`SAMPLE_W-1:0] product;
    logic signed [`ACC_W-1:0]    acc;
    logic signed [`ACC_W-1:0]    acc_shifted;
    logic                        fits;
    sample_t                     sat_data;

    logic                        wet_valid;
    sample_t                     wet_data;

    // **********************************************************************
    // dry sample history, circular
    // **********************************************************************

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            wr_ptr <= '0;
            for (int i = 0; i < `IR_LEN; i++) begin
                hist[i] <= '0;  // pre-reset input reads as silence
            end
        end else if (audio_trigger) begin
            hist[wr_ptr] <= dry_in;
            wr_ptr       <= wr_ptr + 1'b1;
        end
    end

    // x[n-k] for tap k, newest sample sits just behind wr_ptr
    assign hist_idx = wr_ptr - rd_addr - `IR_ADDR_W'(1);

    // **********************************************************************
    // tap sweep control
    // **********************************************************************

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            rd_busy   <= 1'b0;
            rd_addr   <= '0;
            mac_valid <= 1'b0;
            mac_last  <= 1'b0;
            acc_last  <= 1'b0;
            wet_valid <= 1'b0;
            ir_ready  <= 1'b0;
        end else begin
            if (audio_trigger) begin
                rd_busy <= 1'b1;
                rd_addr <= '0;
            end else if (rd_busy) begin
                if (rd_addr == LAST_TAP) begin
                    rd_busy <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            mac_valid <= rd_busy;
            mac_last  <= rd_busy && (rd_addr == LAST_TAP);
            acc_last  <= mac_last;
            wet_valid <= acc_last && ir_ready;  // history runs on while not ready
            if (ir_invalidate) begin
                ir_ready <= 1'b0;
            end else if (ir_loaded) begin
                ir_ready <= 1'b1;
            end
        end
    end

    // **********************************************************************
    // multiply-accumulate and output
    // **********************************************************************

    assign product     = rd_data * x_reg;
    assign acc_shifted = acc >>> (`SAMPLE_W - 1);  // truncating rescale
    assign fits        = (&acc_shifted[`ACC_W-1:`SAMPLE_W-1])
                       | ~(|acc_shifted[`ACC_W-1:`SAMPLE_W-1]);

    always_comb begin
        if (fits) begin
            sat_data = acc_shifted[`SAMPLE_W-1:0];
        end else if (acc_shifted[`ACC_W-1]) begin
            sat_data = {1'b1, {(`SAMPLE_W-1){1'b0}}};  // negative rail
        end else begin
            sat_data = {1'b0, {(`SAMPLE_W-1){1'b1}}};  // positive rail
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rd_busy) begin
            x_reg <= hist[hist_idx];
        end
        if (audio_trigger) begin
            acc <= '0;
        end else if (mac_valid) begin
            acc <= acc + product;
        end
        if (acc_last) begin
            wet_data <= sat_data;
        end
    end

    assign wet = '{valid: wet_valid, data: wet_data};

    // strobes must not overlap a sweep
    a_trigger_spacing: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        audio_trigger |-> !(rd_busy || mac_valid || mac_last || acc_last)
    );

    // fixed latency from strobe to result
    a_wet_latency: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        wet_valid |-> $past(audio_trigger, `IR_LEN + 3)
    );

endmodule

/* hdl/reverb_top.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module reverb_top
    import reverb_pkg::*;
(
    input  logic        audio_clk,
    input  logic        rst_in,
    input  logic        audio_trigger,   // one pulse per sample
    input  logic        record_trigger,
    input  logic [15:0] delay_length,
    input  sample_t     mic_in,
    input  sample_t     dry_in,
    output sample_t     probe_out,       // to speaker path
    output logic        ir_recorded,
    output logic        ir_ready,
    output wet_sample_t wet
);

    ir_write_t             ir_wr;
    logic [`IR_ADDR_W-1:0] rd_addr;
    sample_t               rd_data;

    // **********************************************************************
    // capture side
    // **********************************************************************

    impulse_recorder u_recorder (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .audio_trigger  (audio_trigger),
        .record_trigger (record_trigger),
        .delay_length   (delay_length),
        .mic_in         (mic_in),
        .ir_recorded    (ir_recorded),
        .ir_wr          (ir_wr),
        .probe_out      (probe_out)
    );

    ir_memory u_ir_mem (
        .audio_clk (audio_clk),
        .wr        (ir_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // **********************************************************************
    // playback side
    // **********************************************************************

    ir_convolver u_conv (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .audio_trigger (audio_trigger),
        .dry_in        (dry_in),
        .ir_loaded     (ir_recorded),     // capture done
        .ir_invalidate (record_trigger),  // old taps stale at once
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .ir_ready      (ir_ready),
        .wet           (wet)
    );

endmodule

/* tests/tb_reverb_tasks.svh */
`ifndef TB_REVERB_TASKS_SVH
`define TB_REVERB_TASKS_SVH

// **********************************************************************
// checking and random source
// **********************************************************************

task automatic check_value(input string what, input logic signed [63:0] got,
                           input logic signed [63:0] exp);
    if (got !== exp) begin
        $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        $display("Test FAILED");
        $fatal(1, "mismatch on %s", what);
    end
endtask

function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic longint rand_sample();
    logic [31:0] r;
    r = next_rand();
    return longint'($signed(r[15:0]));
endfunction

// **********************************************************************
// reference convolution
// **********************************************************************

function automatic longint model_wet();
    longint acc;
    acc = 0;
    for (int k = 0; k < `IR_LEN; k++) begin
        acc += model_taps[k] * model_hist[k];
    end
    acc = acc >>> 15;
    if (acc > 32767) begin
        acc = 32767;
    end else if (acc < -32768) begin
        acc = -32768;
    end
    return acc;
endfunction

// one 24-cycle trigger period with the observations kept in globals
task automatic step_sample(input longint dry, input longint mic, input bit rec);
    longint expected;
    bit     exp_valid;
    for (int k = `IR_LEN - 1; k > 0; k--) begin
        model_hist[k] = model_hist[k-1];
    end
    model_hist[0] = dry;
    exp_valid     = model_ready;
    expected      = exp_valid ? model_wet() : 0;
    audio_trigger = 1'b1;
    dry_in        = sample_t'(dry);
    mic_in        = sample_t'(mic);
    @(negedge audio_clk);
    audio_trigger = 1'b0;
    wet_cnt    = 0;
    wet_at     = 0;
    rec_seen   = 0;
    rec_at     = 0;
    probe_amp  = 0;
    probe_zero = 0;
    for (int j = 1; j <= 24; j++) begin
        if (wet.valid) begin
            wet_cnt++;
            wet_at   = j;
            last_wet = wet.data;
        end
        if (ir_recorded) begin
            rec_seen++;
            rec_at = j;
        end
        if (j == 1) ready_j1 = ir_ready;
        if (j == 2) ready_j2 = ir_ready;
        if (probe_out == `IMPULSE_AMP) probe_amp++;
        else if (probe_out == 0) probe_zero++;
        if (rec && j == 20) record_trigger = 1'b1;  // after this period's result
        if (rec && j == 21) begin
            record_trigger = 1'b0;
            check_value("ir_ready after record_trigger", ir_ready, 0);
            model_ready = 1'b0;
        end
        if (j < 24) @(negedge audio_clk);
    end
    check_value("wet.valid pulses", wet_cnt, exp_valid);
    if (exp_valid) begin
        check_value("wet latency", wet_at, `IR_LEN + 3);
        check_value("wet.data", last_wet, expected);
        if (last_wet == 32767) begin
            sat_hi++;  // dut sat on the positive rail
        end else if (last_wet == -32768) begin
            sat_lo++;
        end
    end
endtask

// probe, delay and capture of new_taps
task automatic capture_ir(input int d);
    longint mic;
    delay_length = 16'(d);
    step_sample(0, 0, 1'b1);
    check_value("probe before trigger", probe_zero, 24);
    step_sample(0, 0, 1'b0);
    check_value("probe interval", probe_amp, 24);
    step_sample(0, 0, 1'b0);
    check_value("probe after interval", probe_zero, 24);
    for (int i = 1; i <= d + `IR_LEN; i++) begin
        mic = (i >= d && i < d + `IR_LEN) ? new_taps[i-d] : 4660;
        if (i == d + `IR_LEN) begin
            model_taps  = new_taps;
            model_ready = 1'b1;
        end
        step_sample(0, mic, 1'b0);
        if (i < d + `IR_LEN) begin
            check_value("early ir_recorded", rec_seen, 0);
        end else begin
            check_value("ir_recorded pulses", rec_seen, 1);
            check_value("ir_recorded cycle", rec_at, 1);
            check_value("ir_ready with pulse", ready_j1, 0);
            check_value("ir_ready after pulse", ready_j2, 1);
        end
    end
endtask

`endif

/* tests/tb_reverb.sv */
`timescale 1ns/10ps

`include "reverb_defs.svh"

module tb_reverb
    import reverb_pkg::*;
;

    // tests take about 3900 cycles
    localparam int TIMEOUT = 6000;

    logic        audio_clk;
    logic        rst_in;
    logic        audio_trigger;
    logic        record_trigger;
    logic [15:0] delay_length;
    sample_t     mic_in;
    sample_t     dry_in;
    sample_t     probe_out;
    logic        ir_recorded;
    logic        ir_ready;
    wet_sample_t wet;

    int          cycle_cnt;
    logic [31:0] rng_state;
    longint      model_taps [`IR_LEN];
    longint      model_hist [`IR_LEN];
    longint      new_taps [`IR_LEN];
    bit          model_ready;
    int          sat_hi;
    int          sat_lo;
    int          wet_cnt;
    int          wet_at;
    int          rec_seen;
    int          rec_at;
    int          probe_amp;
    int          probe_zero;
    logic        ready_j1;
    logic        ready_j2;
    sample_t     last_wet;

    reverb_top u_dut (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .audio_trigger  (audio_trigger),
        .record_trigger (record_trigger),
        .delay_length   (delay_length),
        .mic_in         (mic_in),
        .dry_in         (dry_in),
        .probe_out      (probe_out),
        .ir_recorded    (ir_recorded),
        .ir_ready       (ir_ready),
        .wet            (wet)
    );

    always #5 audio_clk = ~audio_clk;

    always @(posedge audio_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    `include "tb_reverb_tasks.svh"

    initial begin
        audio_clk      = 1'b0;
        rst_in         = 1'b1;
        audio_trigger  = 1'b0;
        record_trigger = 1'b0;
        delay_length   = 16'd5;
        mic_in         = '0;
        dry_in         = '0;
        cycle_cnt      = 0;
        rng_state      = 32'hed5c;
        model_ready    = 1'b0;
        sat_hi         = 0;
        sat_lo         = 0;
        for (int k = 0; k < `IR_LEN; k++) begin
            model_taps[k] = 0;
            model_hist[k] = 0;
        end
        repeat (3) @(negedge audio_clk);
        rst_in = 1'b0;

        // reset state
        check_value("probe_out", probe_out, 0);
        check_value("ir_recorded", ir_recorded, 0);
        check_value("ir_ready", ir_ready, 0);
        check_value("wet.valid", wet.valid, 0);
        repeat (3) step_sample(0, 0, 1'b0);

        // ramp capture and impulse replay
        for (int k = 0; k < `IR_LEN; k++) new_taps[k] = (k + 1) * 1000;
        capture_ir(5);
        step_sample(32767, 0, 1'b0);
        check_value("impulse tap 0", last_wet, (32767 * new_taps[0]) >>> 15);
        for (int k = 1; k < `IR_LEN; k++) begin
            step_sample(0, 0, 1'b0);
            check_value("impulse tap", last_wet, (32767 * new_taps[k]) >>> 15);
        end

        // large positive taps driven to both rails
        for (int k = 0; k < `IR_LEN; k++) new_taps[k] = 16384 + (next_rand() & 32'h3fff);
        capture_ir(3);
        sat_hi = 0;
        sat_lo = 0;
        repeat (16) step_sample(32767, 0, 1'b0);
        repeat (16) step_sample(-32768, 0, 1'b0);
        repeat (24) step_sample(rand_sample(), 0, 1'b0);
        check_value("positive rail reached", sat_hi > 0, 1);
        check_value("negative rail reached", sat_lo > 0, 1);

        // re-record with signed random taps
        for (int k = 0; k < `IR_LEN; k++) new_taps[k] = rand_sample();
        capture_ir(2);
        repeat (20) step_sample(rand_sample(), 0, 1'b0);

        $display("Test OK");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
+incdir+tests
hdl/reverb_pkg.sv
hdl/impulse_generator.sv
hdl/impulse_recorder.sv
hdl/ir_memory.sv
hdl/ir_convolver.sv
hdl/reverb_top.sv
tests/tb_reverb.sv

/* Bender.yml */
package:
  name: reverb_ir

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/reverb_pkg.sv
      - hdl/impulse_generator.sv
      - hdl/impulse_recorder.sv
      - hdl/ir_memory.sv
      - hdl/ir_convolver.sv
      - hdl/reverb_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/tb_reverb.sv
